// ==== source/exLanePkg.sv ====
// ========================================
// Shared types for the secondary EX lane
// Commands, ALU ops, packets, register IDs
// ========================================

package exLanePkg;

	// Micro-op command, decoded in EX1 and again in EX2
	typedef enum logic [2:0] {
		UCMD_NOP   = 3'd0,	// No operation, writes zero register
		UCMD_ALU3  = 3'd1,	// Three-operand ALU
		UCMD_MOVIR = 3'd2,	// Immediate to register
		UCMD_LEA   = 3'd3,	// Base plus scaled index
		UCMD_MULW  = 3'd4	// Signed word multiply
	} uCmd_t;

	// ALU3 sub-operation
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLT = 3'd5	// Signed compare, result 1 or 0
	} aluOp_t;

	typedef logic [5:0] gprId_t;	// Register ID

	localparam gprId_t GPR_ZZR = 6'd0;	// Zero register, writes dropped

	// Issue packet, as held in EX1
	typedef struct packed {
		uCmd_t       cmd;
		aluOp_t      aluOp;
		gprId_t      rdId;	// Destination
		logic [63:0] rsVal;	// Source A or LEA base
		logic [63:0] rtVal;	// Source B or LEA index
		logic [32:0] imm;	// Signed immediate, low 2 bits are LEA scale
	} uop_t;

	// Record leaving the lane towards the register file
	typedef struct packed {
		logic        valid;
		gprId_t      rdId;
		logic [63:0] value;
	} writeback_t;

	// Per-unit result held in EX2
	typedef struct packed {
		uCmd_t       cmd;
		gprId_t      rdId;
		logic        valid;
		logic [63:0] value;
	} ex2Res_t;

endpackage

// ==== source/issueAccept.sv ====
// ========================================
// Four-phase req/ack acceptor, EX1 register
// ========================================

module issueAccept (
	input  logic              clock,
	input  logic              arstN,
	input  logic              uopReq,	// Held high with stable packet
	input  exLanePkg::uop_t   uopIn,
	output logic              uopAck,
	output exLanePkg::uop_t   ex1Uop,	// EX1 micro-op register
	output logic              ex1Valid	// One cycle per accepted packet
);

	typedef enum logic {
		IDLE,	// Waiting for a request
		ACKED	// Ack up, waiting for req to drop
	} hsState_t;

	hsState_t state;

	assign uopAck = (state == ACKED);	// Ack is the state itself

	// Handshake FSM and valid pulse
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state    <= IDLE;
			ex1Valid <= 1'b0;
		end else begin
			ex1Valid <= 1'b0;	// Default, pulse only
			case (state)
				IDLE: begin
					if (uopReq) begin
						state    <= ACKED;	// Edge A
						ex1Valid <= 1'b1;
					end
				end
				ACKED: begin
					if (!uopReq)
						state <= IDLE;	// Ack falls, ready again
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Packet capture at acceptance only
	always_ff @(posedge clock) begin
		if (state == IDLE && uopReq)
			ex1Uop <= uopIn;	// Held until next accept
	end

endmodule

// ==== source/aluUnit.sv ====
// ========================================
// Integer unit for ALU3, MOVIR and LEA
// ========================================

module aluUnit (
	input  logic                clock,
	input  logic                arstN,
	input  exLanePkg::uop_t     ex1Uop,
	input  logic                ex1Valid,
	output exLanePkg::ex2Res_t  aluRes	// EX2 result
);

	import exLanePkg::*;

	logic [63:0] aluVal;	// ALU3 sub-op result
	logic [63:0] leaVal;	// Base plus scaled index
	logic [63:0] nextVal;	// EX1 result by command

	logic        resValid;
	uCmd_t       resCmd;
	gprId_t      resRdId;
	logic [63:0] resVal;

	// ALU3 sub-operations
	always_comb begin
		case (ex1Uop.aluOp)
			ALU_ADD: aluVal = ex1Uop.rsVal + ex1Uop.rtVal;
			ALU_SUB: aluVal = ex1Uop.rsVal - ex1Uop.rtVal;
			ALU_AND: aluVal = ex1Uop.rsVal & ex1Uop.rtVal;
			ALU_OR:  aluVal = ex1Uop.rsVal | ex1Uop.rtVal;
			ALU_XOR: aluVal = ex1Uop.rsVal ^ ex1Uop.rtVal;
			ALU_SLT: aluVal = {63'd0, $signed(ex1Uop.rsVal) < $signed(ex1Uop.rtVal)};
			default: aluVal = 64'd0;	// Undefined sub-op
		endcase
	end

	// Scale from the low immediate bits, 1 to 8
	assign leaVal = ex1Uop.rsVal + (ex1Uop.rtVal << ex1Uop.imm[1:0]);

	always_comb begin
		case (ex1Uop.cmd)
			UCMD_ALU3:  nextVal = aluVal;
			UCMD_MOVIR: nextVal = {{31{ex1Uop.imm[32]}}, ex1Uop.imm};	// Sign-extend
			UCMD_LEA:   nextVal = leaVal;
			default:    nextVal = 64'd0;	// NOP and MULW not ours
		endcase
	end

	// EX2 valid
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			resValid <= 1'b0;
		else
			resValid <= ex1Valid;
	end

	// EX2 payload, loaded per operation
	always_ff @(posedge clock) begin
		if (ex1Valid) begin
			resCmd  <= ex1Uop.cmd;
			resRdId <= ex1Uop.rdId;
			resVal  <= nextVal;
		end
	end

	assign aluRes = '{cmd: resCmd, rdId: resRdId, valid: resValid, value: resVal};

endmodule

// ==== source/mulUnit.sv ====
// ========================================
// Signed word multiplier, EX2 result
// ========================================

module mulUnit #(
	parameter int mulWidth = 16	// Operand width, 8, 16 or 32
) (
	input  logic                clock,
	input  logic                arstN,
	input  exLanePkg::uop_t     ex1Uop,
	input  logic                ex1Valid,
	output exLanePkg::ex2Res_t  mulRes	// EX2 result
);

	import exLanePkg::*;

	logic signed [mulWidth-1:0]   opA;	// Low bits of source A
	logic signed [mulWidth-1:0]   opB;	// Low bits of source B
	logic signed [2*mulWidth-1:0] prod;
	logic [63:0]                  prodExt;	// Product widened to 64 bits
	logic                         isMul;

	logic        resValid;
	uCmd_t       resCmd;
	gprId_t      resRdId;
	logic [63:0] resVal;

	// Upper operand bits are ignored
	assign opA  = ex1Uop.rsVal[mulWidth-1:0];
	assign opB  = ex1Uop.rtVal[mulWidth-1:0];
	assign prod = opA * opB;

	assign prodExt = 64'(prod);	// Signed cast sign-extends
	assign isMul   = ex1Valid && (ex1Uop.cmd == UCMD_MULW);

	// EX2 valid
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			resValid <= 1'b0;
		else
			resValid <= ex1Valid;
	end

	// Tags follow every operation
	always_ff @(posedge clock) begin
		if (ex1Valid) begin
			resCmd  <= ex1Uop.cmd;
			resRdId <= ex1Uop.rdId;
		end
	end

	// Value only moves on MULW, less switching
	always_ff @(posedge clock) begin
		if (isMul)
			resVal <= prodExt;
	end

	assign mulRes = '{cmd: resCmd, rdId: resRdId, valid: resValid, value: resVal};

endmodule

// ==== source/writebackSelect.sv ====
// ========================================
// EX2 result select, flush, writeback reg
// ========================================

module writebackSelect (
	input  logic                   clock,
	input  logic                   arstN,
	input  exLanePkg::ex2Res_t     aluRes,
	input  exLanePkg::ex2Res_t     mulRes,
	input  logic                   opBraFlush,	// Kills the op now in EX2
	output exLanePkg::writeback_t  wbOut
);

	import exLanePkg::*;

	gprId_t      selRdId;	// Destination after selection
	logic [63:0] selVal;

	logic        wbValid;
	gprId_t      wbRdId;
	logic [63:0] wbVal;

	// Both records carry the same cmd, decode one
	always_comb begin
		case (aluRes.cmd)
			UCMD_ALU3, UCMD_MOVIR, UCMD_LEA: begin
				selRdId = aluRes.rdId;
				selVal  = aluRes.value;
			end
			UCMD_MULW: begin
				selRdId = mulRes.rdId;
				selVal  = mulRes.value;
			end
			default: begin
				selRdId = GPR_ZZR;	// NOP goes nowhere
				selVal  = 64'd0;
			end
		endcase

		if (opBraFlush) begin
			selRdId = GPR_ZZR;	// Flushed, write is dropped
			selVal  = 64'd0;
		end
	end

	// Writeback valid, one cycle per op
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN)
			wbValid <= 1'b0;
		else
			wbValid <= aluRes.valid;
	end

	always_ff @(posedge clock) begin
		if (aluRes.valid) begin
			wbRdId <= selRdId;
			wbVal  <= selVal;
		end
	end

	assign wbOut = '{valid: wbValid, rdId: wbRdId, value: wbVal};

endmodule

// ==== source/exLaneTop.sv ====
// ========================================
// Secondary EX lane top level
// ========================================

module exLaneTop #(
	parameter int mulWidth = 16	// Multiplier operand width
) (
	input  logic                   clock,
	input  logic                   arstN,
	input  logic                   uopReq,
	input  exLanePkg::uop_t        uopIn,
	output logic                   uopAck,
	input  logic                   opBraFlush,
	output exLanePkg::writeback_t  wbOut
);

	import exLanePkg::*;

	uop_t    ex1Uop;	// EX1 micro-op
	logic    ex1Valid;
	ex2Res_t aluRes;	// EX2 integer result
	ex2Res_t mulRes;	// EX2 multiply result

	issueAccept uAccept (
		.clock    (clock),
		.arstN    (arstN),
		.uopReq   (uopReq),
		.uopIn    (uopIn),
		.uopAck   (uopAck),
		.ex1Uop   (ex1Uop),
		.ex1Valid (ex1Valid)
	);

	aluUnit uAlu (
		.clock    (clock),
		.arstN    (arstN),
		.ex1Uop   (ex1Uop),
		.ex1Valid (ex1Valid),
		.aluRes   (aluRes)
	);

	mulUnit #(.mulWidth(mulWidth)) uMul (
		.clock    (clock),
		.arstN    (arstN),
		.ex1Uop   (ex1Uop),
		.ex1Valid (ex1Valid),
		.mulRes   (mulRes)
	);

	writebackSelect uWbSel (
		.clock      (clock),
		.arstN      (arstN),
		.aluRes     (aluRes),
		.mulRes     (mulRes),
		.opBraFlush (opBraFlush),
		.wbOut      (wbOut)
	);

endmodule

// ==== bench/exLaneMonitor.sv ====
// ========================================
// Checker: reference model, expected queue,
// handshake and writeback comparison
// ========================================

module exLaneMonitor #(
	parameter int mulWidth = 16
) (
	input logic                  clock,
	input logic                  arstN,
	input logic                  uopReq,
	input exLanePkg::uop_t       uopIn,
	input logic                  uopAck,
	input logic                  opBraFlush,
	input exLanePkg::writeback_t wbOut
);
	timeunit 1ns;
	timeprecision 100ps;

	import exLanePkg::*;

	int     errorCount  = 0;
	int     checkCount  = 0;
	int     acceptCount = 0;
	int     wbCount     = 0;
	int     pending     = 0;	// Ops still waiting for writeback
	int     resetEdges  = 0;
	longint cycle       = 0;

	gprId_t      expRd[$];
	logic [63:0] expVal[$];
	longint      dueCycle[$];	// Edge where wbOut must be seen valid

	logic prevAccept = 1'b0;
	logic prevAck    = 1'b0;
	logic prevReq    = 1'b0;
	logic prevFlush  = 1'b0;	// Flush as seen at edge A+2

	function automatic logic [63:0] sext(input logic [63:0] x, input int width);
		return $signed(x << (64 - width)) >>> (64 - width);
	endfunction

	function automatic logic [63:0] modelValue(input uop_t op);
		case (op.cmd)
			UCMD_ALU3: begin
				case (op.aluOp)
					ALU_ADD: return op.rsVal + op.rtVal;
					ALU_SUB: return op.rsVal - op.rtVal;
					ALU_AND: return op.rsVal & op.rtVal;
					ALU_OR:  return op.rsVal | op.rtVal;
					ALU_XOR: return op.rsVal ^ op.rtVal;
					ALU_SLT: begin
						if (op.rsVal[63] != op.rtVal[63])
							return {63'd0, op.rsVal[63]};	// Negative one is less
						return {63'd0, op.rsVal < op.rtVal};	// Same sign keeps unsigned order
					end
					default: return 64'd0;
				endcase
			end
			UCMD_MOVIR: return sext({31'd0, op.imm}, 33);
			UCMD_LEA:   return op.rsVal + op.rtVal * (64'd1 << op.imm[1:0]);	// Index times 1 to 8
			UCMD_MULW:  return sext(op.rsVal, mulWidth) * sext(op.rtVal, mulWidth);	// Low 64 bits
			default:    return 64'd0;
		endcase
	endfunction

	task automatic fail(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errorCount++;
	endtask

	// Compares issue and completion totals
	task automatic checkCounts(input int issued);
		if (acceptCount != issued)
			fail($sformatf("%0d requests issued but %0d accepted", issued, acceptCount));
		if (wbCount != acceptCount)
			fail($sformatf("%0d accepted but %0d writebacks", acceptCount, wbCount));
	endtask

	// All inputs read here are pre-edge values
	always @(posedge clock) begin
		gprId_t      eRd;
		logic [63:0] eVal;
		if (!arstN) begin
			resetEdges++;
			if (resetEdges > 1 && (uopAck !== 1'b0 || wbOut.valid !== 1'b0))
				fail("ack or writeback valid not low during reset");
			prevAccept = 1'b0;
			prevAck    = 1'b0;
			prevReq    = 1'b0;
			prevFlush  = 1'b0;
		end else begin
			cycle++;
			if (prevAccept && uopAck !== 1'b1)
				fail("ack did not rise after an accepted request");
			if (uopAck === 1'b1 && !prevAck && !prevAccept)
				fail("ack rose without a request");
			if (prevAck && !prevReq && uopAck !== 1'b0)
				fail("ack stayed high after the request dropped");

			if (wbOut.valid === 1'b1) begin
				wbCount++;
				if (dueCycle.size() == 0) begin
					fail("writeback valid with no operation pending");
				end else begin
					if (dueCycle[0] != cycle)
						fail("writeback arrived at the wrong cycle");
					eRd  = prevFlush ? GPR_ZZR : expRd[0];	// Flush kills the write
					eVal = prevFlush ? 64'd0 : expVal[0];
					checkCount++;
					if (wbOut.rdId !== eRd) begin
						$display("FAILED at %0t ns: wbOut.rdId expected %0d got %0d",
							$time, eRd, wbOut.rdId);
						errorCount++;
					end
					if (wbOut.value !== eVal) begin
						$display("FAILED at %0t ns: wbOut.value expected %h got %h",
							$time, eVal, wbOut.value);
						errorCount++;
					end
					void'(expRd.pop_front());
					void'(expVal.pop_front());
					void'(dueCycle.pop_front());
				end
			end else if (dueCycle.size() != 0 && dueCycle[0] == cycle) begin
				fail("writeback missing for an accepted request");
				void'(expRd.pop_front());
				void'(expVal.pop_front());
				void'(dueCycle.pop_front());
			end

			prevAccept = (uopReq === 1'b1) && (uopAck === 1'b0);	// Edge A
			if (prevAccept) begin
				acceptCount++;
				expRd.push_back(uopIn.cmd == UCMD_NOP ? GPR_ZZR : uopIn.rdId);
				expVal.push_back(modelValue(uopIn));
				dueCycle.push_back(cycle + 3);	// Loaded at A+2 and seen at A+3
			end
			prevAck   = uopAck;
			prevReq   = uopReq;
			prevFlush = opBraFlush;
		end
		pending = dueCycle.size();
	end

endmodule

// ==== bench/exLaneBench.sv ====
// ========================================
// EX lane testbench top: clock, reset,
// seeded random issue, flush, watchdog
// ========================================

module exLaneBench;
	timeunit 1ns;
	timeprecision 100ps;

	import exLanePkg::*;

	localparam int mulWidth = 16;
	localparam int numAlu   = 60;
	localparam int numMov   = 20;
	localparam int numLea   = 24;
	localparam int numMul   = 30;
	localparam int numKill  = 30;	// NOP and flushed ops
	localparam int numHold  = 12;	// Long req hold after ack
	localparam int numOps   = numAlu + numMov + numLea + numMul + numKill + numHold;
	localparam int watchdogCycles = numOps * 10 + 100;

	logic       clock;
	logic       arstN;
	logic       uopReq;
	uop_t       uopIn;
	logic       uopAck;
	logic       opBraFlush;
	writeback_t wbOut;

	int issued   = 0;	// Requests completed by the bench
	int testsRun = 0;
	int testsBad = 0;
	int errStart = 0;	// Error count at test start
	int opStart  = 0;

	exLaneTop #(.mulWidth(mulWidth)) UUT (
		.clock      (clock),
		.arstN      (arstN),
		.uopReq     (uopReq),
		.uopIn      (uopIn),
		.uopAck     (uopAck),
		.opBraFlush (opBraFlush),
		.wbOut      (wbOut)
	);

	exLaneMonitor #(.mulWidth(mulWidth)) wbCheck (
		.clock      (clock),
		.arstN      (arstN),
		.uopReq     (uopReq),
		.uopIn      (uopIn),
		.uopAck     (uopAck),
		.opBraFlush (opBraFlush),
		.wbOut      (wbOut)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;	// 20 ns period
	end

	initial begin
		repeat (watchdogCycles) @(posedge clock);
		$display("Watchdog expired after %0d cycles, run stopped", watchdogCycles);
		$display("tests failed");
		$finish;
	end

	function automatic logic [63:0] rand64();
		return {$urandom, $urandom};
	endfunction

	// Biased towards the sign boundary
	function automatic logic [63:0] edgeOperand();
		case ($urandom_range(0, 7))
			0: return 64'h8000_0000_0000_0000;
			1: return 64'h7FFF_FFFF_FFFF_FFFF;
			2: return '1;
			3: return 64'd0;
			default: return rand64();
		endcase
	endfunction

	// Random high bits, extreme low word now and then
	function automatic logic [63:0] mulOperand();
		logic [63:0] v;
		v = rand64();
		case ($urandom_range(0, 5))
			0: v[mulWidth-1:0] = {1'b1, {(mulWidth-1){1'b0}}};	// Most negative
			1: v[mulWidth-1:0] = {1'b0, {(mulWidth-1){1'b1}}};	// Most positive
			2: v[mulWidth-1:0] = '1;	// Minus one
			default: ;
		endcase
		return v;
	endfunction

	function automatic uop_t makeUop(input uCmd_t cmd);
		uop_t op;
		op.cmd   = cmd;
		op.aluOp = aluOp_t'($urandom_range(0, 5));
		op.rdId  = gprId_t'($urandom_range(1, 63));	// Never the zero register
		op.rsVal = edgeOperand();
		op.rtVal = edgeOperand();
		op.imm   = {1'($urandom), $urandom};
		return op;
	endfunction

	// One full four-phase handshake
	task automatic issueOp(input uop_t op, input logic flush, input int holdMax);
		int hold;
		hold = $urandom_range(0, holdMax);
		@(posedge clock);
		uopIn  <= op;
		uopReq <= 1'b1;
		@(posedge clock);
		while (uopAck !== 1'b1) @(posedge clock);	// Ack seen at A+1
		opBraFlush <= flush;	// Sampled by EX2 at A+2
		@(posedge clock);
		opBraFlush <= 1'b0;
		repeat (hold) @(posedge clock);	// Req stays up past ack
		uopReq <= 1'b0;
		@(posedge clock);
		while (uopAck !== 1'b0) @(posedge clock);
		issued++;
	endtask

	task automatic endTest(input string name);
		int errs;
		while (wbCheck.pending != 0) @(posedge clock);	// Drain
		errs = wbCheck.errorCount - errStart;
		testsRun++;
		if (errs != 0)
			testsBad++;
		$display("%s: %0d ops, %0d errors, %s", name, issued - opStart, errs,
			errs == 0 ? "ok" : "bad");
		errStart = wbCheck.errorCount;
		opStart  = issued;
	endtask

	initial begin
		uop_t op;
		void'($urandom(27));
		arstN      = 1'b0;
		uopReq     = 1'b0;
		uopIn      = '0;
		opBraFlush = 1'b0;
		repeat (16) @(posedge clock);
		arstN <= 1'b1;
		@(posedge clock);
		endTest("Reset");

		for (int i = 0; i < numAlu; i++)
			issueOp(makeUop(UCMD_ALU3), 1'b0, 1);
		endTest("ALU3");

		for (int i = 0; i < numMov; i++)
			issueOp(makeUop(UCMD_MOVIR), 1'b0, 1);
		endTest("MOVIR");

		for (int i = 0; i < numLea; i++) begin
			op = makeUop(UCMD_LEA);
			op.rsVal    = rand64();
			op.rtVal    = rand64();
			op.imm[1:0] = 2'(i);	// All four scales
			issueOp(op, 1'b0, 1);
		end
		endTest("LEA");

		for (int i = 0; i < numMul; i++) begin
			op = makeUop(UCMD_MULW);
			op.rsVal = mulOperand();
			op.rtVal = mulOperand();
			issueOp(op, 1'b0, 1);
		end
		endTest("MULW");

		for (int i = 0; i < numKill; i++) begin
			if (i % 2 == 0)
				op = makeUop(UCMD_NOP);
			else
				op = makeUop(uCmd_t'($urandom_range(1, 4)));
			issueOp(op, (i % 2 == 1) || ($urandom_range(0, 3) == 0), 1);	// Odd ops flushed
		end
		endTest("NOP and flush");

		for (int i = 0; i < numHold; i++)
			issueOp(makeUop(uCmd_t'($urandom_range(0, 4))), $urandom_range(0, 4) == 0, 4);
		wbCheck.checkCounts(issued);
		endTest("Handshake");

		$display("Summary: %0d tests, %0d with errors, %0d writebacks checked, %0d errors",
			testsRun, testsBad, wbCheck.checkCount, wbCheck.errorCount);
		if (testsBad == 0 && wbCheck.errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== verilog.f ====
source/exLanePkg.sv
source/issueAccept.sv
source/aluUnit.sv
source/mulUnit.sv
source/writebackSelect.sv
source/exLaneTop.sv
bench/exLaneMonitor.sv
bench/exLaneBench.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/100ps -j 0
TOP       = exLaneBench
FILELIST  = verilog.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^all tests passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
